//--- verilog/udp_bridge_pkg.sv
package udp_bridge_pkg;

	// Stream beat layout, 64-bit data with byte enables
	typedef logic [63:0] stream_data_t;
	typedef logic [7:0]  stream_keep_t;

	// Address fields carried in the UDP sideband
	typedef logic [47:0] mac_addr_t;
	typedef logic [31:0] ip_addr_t;
	typedef logic [15:0] udp_port_t;

	// Receive filter, one decision per packet
	typedef enum logic [1:0] {
		RX_IDLE,                           // Waiting for first beat
		RX_PASS,                           // Forwarding to FIFO
		RX_DROP                            // Swallowing up to tlast
	} rx_state_e;

	// Transmit framer, header held for the whole packet
	typedef enum logic {
		TX_IDLE,                           // No packet open
		TX_DATA                            // Header latched
	} tx_state_e;

	// Local station defaults
	localparam mac_addr_t DEF_LOCAL_MAC  = 48'hba0203040506;
	localparam ip_addr_t  DEF_LOCAL_IP   = 32'hc0a8006f;    // 192.168.0.111
	localparam ip_addr_t  DEF_BCAST_IP   = 32'hc0a800ff;    // Subnet broadcast
	localparam udp_port_t DEF_LOCAL_PORT = 16'd10086;       // Listening port

	// Used as destination until a peer is known
	localparam mac_addr_t BCAST_MAC      = 48'hffffffffffff;

endpackage

//--- verilog/async_stream_fifo.sv
`timescale 1ns/100ps

module async_stream_fifo #(
	parameter int ADDR_WIDTH = 4
) (
	input  logic                         wr_clk,
	input  logic                         rd_clk,
	input  logic                         rst_n,

	input  logic                         s_tvalid,
	input  udp_bridge_pkg::stream_data_t s_tdata,
	input  udp_bridge_pkg::stream_keep_t s_tkeep,
	input  logic                         s_tlast,
	output logic                         s_tready,

	output logic                         m_tvalid,
	output udp_bridge_pkg::stream_data_t m_tdata,
	output udp_bridge_pkg::stream_keep_t m_tkeep,
	output logic                         m_tlast,
	input  logic                         m_tready
);

	import udp_bridge_pkg::*;

	localparam int DEPTH = 1 << ADDR_WIDTH;
	localparam int PTR_W = ADDR_WIDTH + 1;    // Extra wrap bit

	stream_data_t mem_data [DEPTH];
	stream_keep_t mem_keep [DEPTH];
	logic         mem_last [DEPTH];

	logic [PTR_W-1:0] wr_bin;
	logic [PTR_W-1:0] wr_gray;
	logic [PTR_W-1:0] wr_bin_next;
	logic [PTR_W-1:0] wr_gray_next;
	logic [PTR_W-1:0] rd_bin;
	logic [PTR_W-1:0] rd_gray;
	logic [PTR_W-1:0] rd_bin_next;
	logic [PTR_W-1:0] rd_gray_next;

	logic [PTR_W-1:0] rd_gray_sync1;          // Read pointer into wr_clk
	logic [PTR_W-1:0] rd_gray_sync2;
	logic [PTR_W-1:0] wr_gray_sync1;          // Write pointer into rd_clk
	logic [PTR_W-1:0] wr_gray_sync2;

	logic full;
	logic empty;
	logic push;
	logic pop;

	// Write side
	assign push         = s_tvalid && s_tready;
	assign wr_bin_next  = wr_bin + PTR_W'(push);
	assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;

	// Full when the top two Gray bits differ and the rest match
	assign full     = (wr_gray ^ rd_gray_sync2) == {2'b11, {(PTR_W-2){1'b0}}};
	assign s_tready = !full;

	always_ff @(posedge wr_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_bin  <= '0;
			wr_gray <= '0;
		end else begin
			wr_bin  <= wr_bin_next;
			wr_gray <= wr_gray_next;
		end
	end

	always_ff @(posedge wr_clk) begin
		if (push) begin
			mem_data[wr_bin[ADDR_WIDTH-1:0]] <= s_tdata;
			mem_keep[wr_bin[ADDR_WIDTH-1:0]] <= s_tkeep;
			mem_last[wr_bin[ADDR_WIDTH-1:0]] <= s_tlast;
		end
	end

	always_ff @(posedge wr_clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_gray_sync1 <= '0;
			rd_gray_sync2 <= '0;
		end else begin
			rd_gray_sync1 <= rd_gray;
			rd_gray_sync2 <= rd_gray_sync1;
		end
	end

	// Read side, first word falls through
	assign pop          = m_tvalid && m_tready;
	assign rd_bin_next  = rd_bin + PTR_W'(pop);
	assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;

	assign empty    = rd_gray == wr_gray_sync2;
	assign m_tvalid = !empty;
	assign m_tdata  = mem_data[rd_bin[ADDR_WIDTH-1:0]];
	assign m_tkeep  = mem_keep[rd_bin[ADDR_WIDTH-1:0]];
	assign m_tlast  = mem_last[rd_bin[ADDR_WIDTH-1:0]];

	always_ff @(posedge rd_clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_bin  <= '0;
			rd_gray <= '0;
		end else begin
			rd_bin  <= rd_bin_next;
			rd_gray <= rd_gray_next;
		end
	end

	always_ff @(posedge rd_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_gray_sync1 <= '0;
			wr_gray_sync2 <= '0;
		end else begin
			wr_gray_sync1 <= wr_gray;
			wr_gray_sync2 <= wr_gray_sync1;
		end
	end

	// Binary form of a Gray pointer
	function automatic logic [PTR_W-1:0] gray_to_bin(input logic [PTR_W-1:0] gray);
		logic [PTR_W-1:0] bin;
		bin[PTR_W-1] = gray[PTR_W-1];
		for (int i = PTR_W - 2; i >= 0; i--)
			bin[i] = bin[i+1] ^ gray[i];
		return bin;
	endfunction

	// Writer never more than DEPTH entries ahead of the synchronised reader
	a_no_write_when_full: assert property (
		@(posedge wr_clk) disable iff (!rst_n)
		PTR_W'(wr_bin - gray_to_bin(rd_gray_sync2)) <= PTR_W'(DEPTH)
	) else $error("async_stream_fifo: write pointer ran past the read pointer");

endmodule

//--- verilog/udp_rx_filter.sv
`timescale 1ns/100ps

module udp_rx_filter #(
	parameter udp_bridge_pkg::ip_addr_t  LOCAL_IP   = udp_bridge_pkg::DEF_LOCAL_IP,
	parameter udp_bridge_pkg::ip_addr_t  BCAST_IP   = udp_bridge_pkg::DEF_BCAST_IP,
	parameter udp_bridge_pkg::udp_port_t LOCAL_PORT = udp_bridge_pkg::DEF_LOCAL_PORT
) (
	input  logic                         udp_clk,
	input  logic                         rst_n,

	input  logic                         udp_rx_tvalid,
	input  logic                         udp_rx_tlast,
	input  udp_bridge_pkg::stream_keep_t udp_rx_tkeep,
	input  udp_bridge_pkg::stream_data_t udp_rx_tdata,
	input  udp_bridge_pkg::mac_addr_t    udp_rx_mac_src,
	input  udp_bridge_pkg::ip_addr_t     udp_rx_ip_src,
	input  udp_bridge_pkg::ip_addr_t     udp_rx_ip_dest,
	input  udp_bridge_pkg::udp_port_t    udp_rx_port_src,
	input  udp_bridge_pkg::udp_port_t    udp_rx_port_dest,
	output logic                         udp_rx_tready,

	output logic                         fifo_tvalid,
	output udp_bridge_pkg::stream_data_t fifo_tdata,
	output udp_bridge_pkg::stream_keep_t fifo_tkeep,
	output logic                         fifo_tlast,
	input  logic                         fifo_tready,

	output udp_bridge_pkg::mac_addr_t    peer_mac,
	output udp_bridge_pkg::ip_addr_t     peer_ip,
	output udp_bridge_pkg::udp_port_t    peer_port,
	output logic                         peer_valid
);

	import udp_bridge_pkg::*;

	rx_state_e state;
	rx_state_e state_next;

	logic accept;
	logic pass_beat;
	logic xfer;
	logic mid_packet;    // Set between first beat and tlast

	// Sideband is only meaningful with the first beat
	assign accept = (udp_rx_port_dest == LOCAL_PORT) &&
	                ((udp_rx_ip_dest == LOCAL_IP) || (udp_rx_ip_dest == BCAST_IP));

	assign pass_beat = (state == RX_PASS) || ((state == RX_IDLE) && accept);

	assign fifo_tvalid   = udp_rx_tvalid && pass_beat;
	assign fifo_tdata    = udp_rx_tdata;
	assign fifo_tkeep    = udp_rx_tkeep;
	assign fifo_tlast    = udp_rx_tlast;
	assign udp_rx_tready = pass_beat ? fifo_tready : 1'b1;    // Drop never stalls

	assign xfer = udp_rx_tvalid && udp_rx_tready;

	always_comb begin
		state_next = state;
		case (state)
			RX_IDLE: begin
				if (xfer && !udp_rx_tlast)
					state_next = accept ? RX_PASS : RX_DROP;
			end
			RX_PASS, RX_DROP: begin
				if (xfer && udp_rx_tlast)
					state_next = RX_IDLE;
			end
			default: state_next = RX_IDLE;
		endcase
	end

	always_ff @(posedge udp_clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= RX_IDLE;
			peer_valid <= 1'b0;
		end else begin
			state <= state_next;
			if (state == RX_IDLE && xfer && accept)
				peer_valid <= 1'b1;
		end
	end

	// Peer follows the last accepted packet
	always_ff @(posedge udp_clk) begin
		if (state == RX_IDLE && xfer && accept) begin
			peer_mac  <= udp_rx_mac_src;
			peer_ip   <= udp_rx_ip_src;
			peer_port <= udp_rx_port_src;
		end
	end

	// Packet boundaries seen from the stream alone
	always_ff @(posedge udp_clk or negedge rst_n) begin
		if (!rst_n)
			mid_packet <= 1'b0;
		else if (xfer)
			mid_packet <= !udp_rx_tlast;
	end

	a_pkt_boundary: assert property (
		@(posedge udp_clk) disable iff (!rst_n)
		(state != RX_IDLE) == mid_packet
	) else $error("udp_rx_filter: packet state out of step with tlast");

endmodule

//--- verilog/udp_tx_framer.sv
`timescale 1ns/100ps

module udp_tx_framer #(
	parameter udp_bridge_pkg::mac_addr_t LOCAL_MAC  = udp_bridge_pkg::DEF_LOCAL_MAC,
	parameter udp_bridge_pkg::ip_addr_t  LOCAL_IP   = udp_bridge_pkg::DEF_LOCAL_IP,
	parameter udp_bridge_pkg::ip_addr_t  BCAST_IP   = udp_bridge_pkg::DEF_BCAST_IP,
	parameter udp_bridge_pkg::udp_port_t LOCAL_PORT = udp_bridge_pkg::DEF_LOCAL_PORT
) (
	input  logic                         udp_clk,
	input  logic                         rst_n,

	input  logic                         fifo_tvalid,
	input  udp_bridge_pkg::stream_data_t fifo_tdata,
	input  udp_bridge_pkg::stream_keep_t fifo_tkeep,
	input  logic                         fifo_tlast,
	output logic                         fifo_tready,

	input  udp_bridge_pkg::mac_addr_t    peer_mac,
	input  udp_bridge_pkg::ip_addr_t     peer_ip,
	input  udp_bridge_pkg::udp_port_t    peer_port,
	input  logic                         peer_valid,

	output logic                         udp_tx_tvalid,
	output logic                         udp_tx_tlast,
	output udp_bridge_pkg::stream_keep_t udp_tx_tkeep,
	output udp_bridge_pkg::stream_data_t udp_tx_tdata,
	output udp_bridge_pkg::mac_addr_t    udp_tx_mac_src,
	output udp_bridge_pkg::mac_addr_t    udp_tx_mac_dest,
	output udp_bridge_pkg::ip_addr_t     udp_tx_ip_src,
	output udp_bridge_pkg::ip_addr_t     udp_tx_ip_dest,
	output udp_bridge_pkg::udp_port_t    udp_tx_port_src,
	output udp_bridge_pkg::udp_port_t    udp_tx_port_dest,
	input  logic                         udp_tx_tready
);

	import udp_bridge_pkg::*;

	tx_state_e state;

	mac_addr_t dest_mac_sel;
	ip_addr_t  dest_ip_sel;
	udp_port_t dest_port_sel;
	mac_addr_t hdr_mac;
	ip_addr_t  hdr_ip;
	udp_port_t hdr_port;

	// Beats pass straight from the FIFO
	assign udp_tx_tvalid = fifo_tvalid;
	assign udp_tx_tlast  = fifo_tlast;
	assign udp_tx_tkeep  = fifo_tkeep;
	assign udp_tx_tdata  = fifo_tdata;
	assign fifo_tready   = udp_tx_tready;

	// Broadcast until a peer has been heard from
	assign dest_mac_sel  = peer_valid ? peer_mac  : BCAST_MAC;
	assign dest_ip_sel   = peer_valid ? peer_ip   : BCAST_IP;
	assign dest_port_sel = peer_valid ? peer_port : LOCAL_PORT;

	assign udp_tx_mac_src   = LOCAL_MAC;
	assign udp_tx_ip_src    = LOCAL_IP;
	assign udp_tx_port_src  = LOCAL_PORT;
	assign udp_tx_mac_dest  = (state == TX_IDLE) ? dest_mac_sel  : hdr_mac;
	assign udp_tx_ip_dest   = (state == TX_IDLE) ? dest_ip_sel   : hdr_ip;
	assign udp_tx_port_dest = (state == TX_IDLE) ? dest_port_sel : hdr_port;

	always_ff @(posedge udp_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= TX_IDLE;
		end else begin
			case (state)
				TX_IDLE: begin
					if (fifo_tvalid && !(udp_tx_tready && fifo_tlast))
						state <= TX_DATA;    // Single-beat packet stays idle
				end
				TX_DATA: begin
					if (fifo_tvalid && udp_tx_tready && fifo_tlast)
						state <= TX_IDLE;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge udp_clk) begin
		if (state == TX_IDLE && fifo_tvalid) begin
			hdr_mac  <= dest_mac_sel;
			hdr_ip   <= dest_ip_sel;
			hdr_port <= dest_port_sel;
		end
	end

	a_hdr_stable: assert property (
		@(posedge udp_clk) disable iff (!rst_n)
		udp_tx_tvalid && !udp_tx_tready |=>
			$stable(udp_tx_mac_dest) && $stable(udp_tx_ip_dest) && $stable(udp_tx_port_dest)
	) else $error("udp_tx_framer: header changed during stall");

endmodule

//--- verilog/udp_bridge_top.sv
`timescale 1ns/100ps

module udp_bridge_top #(
	parameter udp_bridge_pkg::mac_addr_t LOCAL_MAC       = udp_bridge_pkg::DEF_LOCAL_MAC,
	parameter udp_bridge_pkg::ip_addr_t  LOCAL_IP        = udp_bridge_pkg::DEF_LOCAL_IP,
	parameter udp_bridge_pkg::ip_addr_t  BCAST_IP        = udp_bridge_pkg::DEF_BCAST_IP,
	parameter udp_bridge_pkg::udp_port_t LOCAL_PORT      = udp_bridge_pkg::DEF_LOCAL_PORT,
	parameter int                        FIFO_ADDR_WIDTH = 4
) (
	input  logic                         ui_clk,
	input  logic                         udp_clk,
	input  logic                         rst_n,

	input  logic                         tx_axis_tvalid,     // User transmit stream
	output logic                         tx_axis_tready,
	input  udp_bridge_pkg::stream_data_t tx_axis_tdata,
	input  udp_bridge_pkg::stream_keep_t tx_axis_tkeep,
	input  logic                         tx_axis_tlast,

	output logic                         rx_axis_tvalid,     // User receive stream
	input  logic                         rx_axis_tready,
	output udp_bridge_pkg::stream_data_t rx_axis_tdata,
	output udp_bridge_pkg::stream_keep_t rx_axis_tkeep,
	output logic                         rx_axis_tlast,

	output logic                         udp_tx_tvalid,      // Toward UDP MAC
	output logic                         udp_tx_tlast,
	output udp_bridge_pkg::stream_keep_t udp_tx_tkeep,
	output udp_bridge_pkg::stream_data_t udp_tx_tdata,
	output udp_bridge_pkg::mac_addr_t    udp_tx_mac_src,
	output udp_bridge_pkg::mac_addr_t    udp_tx_mac_dest,
	output udp_bridge_pkg::ip_addr_t     udp_tx_ip_src,
	output udp_bridge_pkg::ip_addr_t     udp_tx_ip_dest,
	output udp_bridge_pkg::udp_port_t    udp_tx_port_src,
	output udp_bridge_pkg::udp_port_t    udp_tx_port_dest,
	input  logic                         udp_tx_tready,

	input  logic                         udp_rx_tvalid,      // From UDP MAC
	input  logic                         udp_rx_tlast,
	input  udp_bridge_pkg::stream_keep_t udp_rx_tkeep,
	input  udp_bridge_pkg::stream_data_t udp_rx_tdata,
	input  udp_bridge_pkg::mac_addr_t    udp_rx_mac_src,
	input  udp_bridge_pkg::ip_addr_t     udp_rx_ip_src,
	input  udp_bridge_pkg::ip_addr_t     udp_rx_ip_dest,
	input  udp_bridge_pkg::udp_port_t    udp_rx_port_src,
	input  udp_bridge_pkg::udp_port_t    udp_rx_port_dest,
	output logic                         udp_rx_tready
);

	import udp_bridge_pkg::*;

	// Filter to receive FIFO, udp_clk
	logic         rx_fifo_tvalid;
	logic         rx_fifo_tready;
	stream_data_t rx_fifo_tdata;
	stream_keep_t rx_fifo_tkeep;
	logic         rx_fifo_tlast;

	// Transmit FIFO to framer, udp_clk
	logic         tx_fifo_tvalid;
	logic         tx_fifo_tready;
	stream_data_t tx_fifo_tdata;
	stream_keep_t tx_fifo_tkeep;
	logic         tx_fifo_tlast;

	mac_addr_t    peer_mac;
	ip_addr_t     peer_ip;
	udp_port_t    peer_port;
	logic         peer_valid;

	udp_rx_filter #(
		.LOCAL_IP   (LOCAL_IP),
		.BCAST_IP   (BCAST_IP),
		.LOCAL_PORT (LOCAL_PORT)
	) rx_filter0 (
		.udp_clk          (udp_clk),
		.rst_n            (rst_n),
		.udp_rx_tvalid    (udp_rx_tvalid),
		.udp_rx_tlast     (udp_rx_tlast),
		.udp_rx_tkeep     (udp_rx_tkeep),
		.udp_rx_tdata     (udp_rx_tdata),
		.udp_rx_mac_src   (udp_rx_mac_src),
		.udp_rx_ip_src    (udp_rx_ip_src),
		.udp_rx_ip_dest   (udp_rx_ip_dest),
		.udp_rx_port_src  (udp_rx_port_src),
		.udp_rx_port_dest (udp_rx_port_dest),
		.udp_rx_tready    (udp_rx_tready),
		.fifo_tvalid      (rx_fifo_tvalid),
		.fifo_tdata       (rx_fifo_tdata),
		.fifo_tkeep       (rx_fifo_tkeep),
		.fifo_tlast       (rx_fifo_tlast),
		.fifo_tready      (rx_fifo_tready),
		.peer_mac         (peer_mac),
		.peer_ip          (peer_ip),
		.peer_port        (peer_port),
		.peer_valid       (peer_valid)
	);

	async_stream_fifo #(
		.ADDR_WIDTH (FIFO_ADDR_WIDTH)
	) rx_fifo0 (
		.wr_clk   (udp_clk),
		.rd_clk   (ui_clk),
		.rst_n    (rst_n),
		.s_tvalid (rx_fifo_tvalid),
		.s_tdata  (rx_fifo_tdata),
		.s_tkeep  (rx_fifo_tkeep),
		.s_tlast  (rx_fifo_tlast),
		.s_tready (rx_fifo_tready),
		.m_tvalid (rx_axis_tvalid),
		.m_tdata  (rx_axis_tdata),
		.m_tkeep  (rx_axis_tkeep),
		.m_tlast  (rx_axis_tlast),
		.m_tready (rx_axis_tready)
	);

	async_stream_fifo #(
		.ADDR_WIDTH (FIFO_ADDR_WIDTH)
	) tx_fifo0 (
		.wr_clk   (ui_clk),
		.rd_clk   (udp_clk),
		.rst_n    (rst_n),
		.s_tvalid (tx_axis_tvalid),
		.s_tdata  (tx_axis_tdata),
		.s_tkeep  (tx_axis_tkeep),
		.s_tlast  (tx_axis_tlast),
		.s_tready (tx_axis_tready),
		.m_tvalid (tx_fifo_tvalid),
		.m_tdata  (tx_fifo_tdata),
		.m_tkeep  (tx_fifo_tkeep),
		.m_tlast  (tx_fifo_tlast),
		.m_tready (tx_fifo_tready)
	);

	udp_tx_framer #(
		.LOCAL_MAC  (LOCAL_MAC),
		.LOCAL_IP   (LOCAL_IP),
		.BCAST_IP   (BCAST_IP),
		.LOCAL_PORT (LOCAL_PORT)
	) tx_framer0 (
		.udp_clk          (udp_clk),
		.rst_n            (rst_n),
		.fifo_tvalid      (tx_fifo_tvalid),
		.fifo_tdata       (tx_fifo_tdata),
		.fifo_tkeep       (tx_fifo_tkeep),
		.fifo_tlast       (tx_fifo_tlast),
		.fifo_tready      (tx_fifo_tready),
		.peer_mac         (peer_mac),
		.peer_ip          (peer_ip),
		.peer_port        (peer_port),
		.peer_valid       (peer_valid),
		.udp_tx_tvalid    (udp_tx_tvalid),
		.udp_tx_tlast     (udp_tx_tlast),
		.udp_tx_tkeep     (udp_tx_tkeep),
		.udp_tx_tdata     (udp_tx_tdata),
		.udp_tx_mac_src   (udp_tx_mac_src),
		.udp_tx_mac_dest  (udp_tx_mac_dest),
		.udp_tx_ip_src    (udp_tx_ip_src),
		.udp_tx_ip_dest   (udp_tx_ip_dest),
		.udp_tx_port_src  (udp_tx_port_src),
		.udp_tx_port_dest (udp_tx_port_dest),
		.udp_tx_tready    (udp_tx_tready)
	);

endmodule

//--- verification/udp_bridge_model.svh
`ifndef UDP_BRIDGE_MODEL_SVH
`define UDP_BRIDGE_MODEL_SVH

// Beats the DUT still owes, packed as {last, keep, data}
logic [72:0] tx_expect_q[$];
logic [72:0] rx_expect_q[$];

// Source of each accepted packet in flight, {mac, ip, port}
logic [95:0] rx_peer_q[$];

// Reply address the DUT should be using
logic      peer_known;
mac_addr_t peer_mac_exp;
ip_addr_t  peer_ip_exp;
udp_port_t peer_port_exp;

function automatic void model_reset();
	tx_expect_q.delete();
	rx_expect_q.delete();
	rx_peer_q.delete();
	peer_known    = 1'b0;                  // Nothing accepted yet
	peer_mac_exp  = '0;
	peer_ip_exp   = '0;
	peer_port_exp = '0;
endfunction

function automatic void expect_tx_beat(input logic last, input stream_keep_t keep,
	input stream_data_t data);
	tx_expect_q.push_back({last, keep, data});
endfunction

function automatic void expect_rx_beat(input logic last, input stream_keep_t keep,
	input stream_data_t data);
	rx_expect_q.push_back({last, keep, data});
endfunction

// An accepted packet has fully left rx_axis
function automatic void note_peer(input logic [95:0] src);
	peer_known    = 1'b1;
	peer_mac_exp  = src[95:48];
	peer_ip_exp   = src[47:16];
	peer_port_exp = src[15:0];
endfunction

// Broadcast destination until the first accepted packet
function automatic mac_addr_t expected_dest_mac();
	return peer_known ? peer_mac_exp : BCAST_MAC;
endfunction

function automatic ip_addr_t expected_dest_ip();
	return peer_known ? peer_ip_exp : DEF_BCAST_IP;
endfunction

function automatic udp_port_t expected_dest_port();
	return peer_known ? peer_port_exp : DEF_LOCAL_PORT;
endfunction

`endif

//--- verification/udp_bridge_tb.sv
`timescale 1ns/100ps

module udp_bridge_tb;

	import udp_bridge_pkg::*;

	localparam int TIMEOUT_CYCLES = 2000;

	logic ui_clk = 1'b0;
	logic udp_clk = 1'b0;
	logic rst_n;

	logic         tx_axis_tvalid;
	logic         tx_axis_tready;
	stream_data_t tx_axis_tdata;
	stream_keep_t tx_axis_tkeep;
	logic         tx_axis_tlast;

	logic         rx_axis_tvalid;
	logic         rx_axis_tready = 1'b0;
	stream_data_t rx_axis_tdata;
	stream_keep_t rx_axis_tkeep;
	logic         rx_axis_tlast;

	logic         udp_tx_tvalid;
	logic         udp_tx_tlast;
	stream_keep_t udp_tx_tkeep;
	stream_data_t udp_tx_tdata;
	mac_addr_t    udp_tx_mac_src;
	mac_addr_t    udp_tx_mac_dest;
	ip_addr_t     udp_tx_ip_src;
	ip_addr_t     udp_tx_ip_dest;
	udp_port_t    udp_tx_port_src;
	udp_port_t    udp_tx_port_dest;
	logic         udp_tx_tready = 1'b0;

	logic         udp_rx_tvalid;
	logic         udp_rx_tlast;
	stream_keep_t udp_rx_tkeep;
	stream_data_t udp_rx_tdata;
	mac_addr_t    udp_rx_mac_src;
	ip_addr_t     udp_rx_ip_src;
	ip_addr_t     udp_rx_ip_dest;
	udp_port_t    udp_rx_port_src;
	udp_port_t    udp_rx_port_dest;
	logic         udp_rx_tready;

	integer seed = 22079;
	int     error_count = 0;
	int     tests_passed = 0;
	int     tests_failed = 0;

	`include "udp_bridge_model.svh"

	udp_bridge_top dut0 (.*);

	always #4 udp_clk = ~udp_clk;
	always #5 ui_clk = ~ui_clk;

	// Random sink stalls, about one cycle in four
	always @(posedge udp_clk) begin
		#1;
		udp_tx_tready = ($random(seed) & 3) != 0;
	end

	always @(posedge ui_clk) begin
		#1;
		rx_axis_tready = ($random(seed) & 3) != 0;
	end

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			$display("FAIL %s: got %0h, expected %0h", name, actual, expected);
			error_count++;
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (error_count == errors_before) begin
			$display("PASS %s", name);
			tests_passed++;
		end else begin
			$display("FAIL %s with %0d errors", name, error_count - errors_before);
			tests_failed++;
		end
	endtask

	always @(posedge udp_clk) begin : tx_monitor
		logic [72:0] exp;
		if (rst_n && udp_tx_tvalid && udp_tx_tready) begin
			if (tx_expect_q.size() == 0) begin
				$display("Unexpected beat on udp_tx, data %0h", udp_tx_tdata);
				error_count++;
			end else begin
				exp = tx_expect_q.pop_front();
				check_value("udp_tx_tdata", udp_tx_tdata, exp[63:0]);
				check_value("udp_tx_tkeep", 64'(udp_tx_tkeep), 64'(exp[71:64]));
				check_value("udp_tx_tlast", 64'(udp_tx_tlast), 64'(exp[72]));
				// Header checked on every beat, so it must hold over the packet
				check_value("udp_tx_mac_src", 64'(udp_tx_mac_src), 64'(DEF_LOCAL_MAC));
				check_value("udp_tx_ip_src", 64'(udp_tx_ip_src), 64'(DEF_LOCAL_IP));
				check_value("udp_tx_port_src", 64'(udp_tx_port_src), 64'(DEF_LOCAL_PORT));
				check_value("udp_tx_mac_dest", 64'(udp_tx_mac_dest), 64'(expected_dest_mac()));
				check_value("udp_tx_ip_dest", 64'(udp_tx_ip_dest), 64'(expected_dest_ip()));
				check_value("udp_tx_port_dest", 64'(udp_tx_port_dest),
					64'(expected_dest_port()));
			end
		end
	end

	always @(posedge ui_clk) begin : rx_monitor
		logic [72:0] exp;
		if (rst_n && rx_axis_tvalid && rx_axis_tready) begin
			if (rx_expect_q.size() == 0) begin
				$display("Unexpected beat on rx_axis, data %0h", rx_axis_tdata);
				error_count++;
			end else begin
				exp = rx_expect_q.pop_front();
				check_value("rx_axis_tdata", rx_axis_tdata, exp[63:0]);
				check_value("rx_axis_tkeep", 64'(rx_axis_tkeep), 64'(exp[71:64]));
				check_value("rx_axis_tlast", 64'(rx_axis_tlast), 64'(exp[72]));
				if (exp[72] && rx_peer_q.size() != 0)
					note_peer(rx_peer_q.pop_front());    // Packet delivered
			end
		end
	end

	task automatic wait_tx_accept();
		int waited;
		waited = 0;
		@(posedge ui_clk);
		while (!tx_axis_tready) begin
			if (waited == TIMEOUT_CYCLES)
				stop_on_timeout("tx_axis_tready");
			waited++;
			@(posedge ui_clk);
		end
		#1;
	endtask

	task automatic wait_rx_accept();
		int waited;
		waited = 0;
		@(posedge udp_clk);
		while (!udp_rx_tready) begin
			if (waited == TIMEOUT_CYCLES)
				stop_on_timeout("udp_rx_tready");
			waited++;
			@(posedge udp_clk);
		end
		#1;
	endtask

	// Also serves as the udp_tx idle wait
	task automatic wait_tx_drained();
		int waited;
		waited = 0;
		while (tx_expect_q.size() != 0 || udp_tx_tvalid) begin
			if (waited == TIMEOUT_CYCLES)
				stop_on_timeout("udp_tx to drain");
			waited++;
			@(posedge udp_clk);
		end
	endtask

	task automatic wait_rx_drained();
		int waited;
		waited = 0;
		while (rx_expect_q.size() != 0 || rx_axis_tvalid) begin
			if (waited == TIMEOUT_CYCLES)
				stop_on_timeout("rx_axis to drain");
			waited++;
			@(posedge ui_clk);
		end
	endtask

	task automatic send_tx_packet(input int len);
		@(posedge ui_clk);
		#1;
		for (int i = 0; i < len; i++) begin
			tx_axis_tvalid = 1'b1;
			tx_axis_tdata  = {$random(seed), $random(seed)};
			tx_axis_tkeep  = 8'($random(seed));
			tx_axis_tlast  = (i == len - 1);
			expect_tx_beat(tx_axis_tlast, tx_axis_tkeep, tx_axis_tdata);
			wait_tx_accept();
		end
		tx_axis_tvalid = 1'b0;
	endtask

	// Kind 0 local, 1 broadcast, 2 wrong port, 3 foreign IP
	task automatic send_rx_packet(input int kind, input int len);
		@(posedge udp_clk);
		#1;
		udp_rx_mac_src   = 48'({$random(seed), $random(seed)});
		udp_rx_ip_src    = $random(seed);
		udp_rx_port_src  = 16'($random(seed));
		udp_rx_ip_dest   = (kind == 1) ? DEF_BCAST_IP : DEF_LOCAL_IP;
		udp_rx_port_dest = DEF_LOCAL_PORT;
		if (kind == 2)
			udp_rx_port_dest = DEF_LOCAL_PORT ^ (16'($random(seed)) | 16'h0001);
		if (kind == 3)
			udp_rx_ip_dest = {8'h0a, 24'($random(seed))};    // Never 192.168.x.x
		if (kind < 2)
			rx_peer_q.push_back({udp_rx_mac_src, udp_rx_ip_src, udp_rx_port_src});
		for (int i = 0; i < len; i++) begin
			udp_rx_tvalid = 1'b1;
			udp_rx_tdata  = {$random(seed), $random(seed)};
			udp_rx_tkeep  = 8'($random(seed));
			udp_rx_tlast  = (i == len - 1);
			if (kind < 2)
				expect_rx_beat(udp_rx_tlast, udp_rx_tkeep, udp_rx_tdata);
			wait_rx_accept();
		end
		udp_rx_tvalid = 1'b0;
	endtask

	initial begin
		int errs;
		rst_n            = 1'b0;
		tx_axis_tvalid   = 1'b0;
		tx_axis_tdata    = '0;
		tx_axis_tkeep    = '0;
		tx_axis_tlast    = 1'b0;
		udp_rx_tvalid    = 1'b0;
		udp_rx_tlast     = 1'b0;
		udp_rx_tkeep     = '0;
		udp_rx_tdata     = '0;
		udp_rx_mac_src   = '0;
		udp_rx_ip_src    = '0;
		udp_rx_ip_dest   = '0;
		udp_rx_port_src  = '0;
		udp_rx_port_dest = '0;
		model_reset();
		repeat (10) @(posedge udp_clk);
		#1;
		rst_n = 1'b1;

		errs = error_count;
		for (int p = 0; p < 12; p++)
			send_tx_packet(1 + ($random(seed) & 7));
		wait_tx_drained();
		finish_test("tx_data", errs);

		// Longer packets than the FIFO holds, peer still unknown
		errs = error_count;
		for (int p = 0; p < 8; p++)
			send_tx_packet(1 + ($random(seed) & 31));
		wait_tx_drained();
		finish_test("tx_broadcast_header", errs);

		errs = error_count;
		for (int p = 0; p < 12; p++)
			send_rx_packet($random(seed) & 1, 1 + ($random(seed) & 15));
		wait_rx_drained();
		finish_test("rx_accept", errs);

		errs = error_count;
		for (int p = 0; p < 16; p++)
			send_rx_packet($random(seed) & 3, 1 + ($random(seed) & 7));
		wait_rx_drained();
		finish_test("rx_reject", errs);

		errs = error_count;
		send_rx_packet(0, 3);
		send_rx_packet(2 + ($random(seed) & 1), 2);    // Rejected, peer must not move
		wait_rx_drained();
		wait_tx_drained();
		for (int p = 0; p < 4; p++)
			send_tx_packet(1 + ($random(seed) & 7));
		wait_tx_drained();
		finish_test("reply_address", errs);

		$display("Tests: %0d passed, %0d failed, %0d check errors",
			tests_passed, tests_failed, error_count);
		if (tests_failed == 0 && error_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- project.f
+incdir+verification
verilog/udp_bridge_pkg.sv
verilog/async_stream_fifo.sv
verilog/udp_rx_filter.sv
verilog/udp_tx_framer.sv
verilog/udp_bridge_top.sv
verification/udp_bridge_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the UDP bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f project.f --top-module udp_bridge_tb \
	-Mdir "$BUILD_DIR" -o udp_bridge_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"$BUILD_DIR/udp_bridge_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	exit 1
fi
exit 0
